// ==== all.f ====
+incdir+common
common/swcPkg.sv
hdl/cmdReceiver.sv
hdl/cmdDispatch.sv
swc/swcCounter.sv
hdl/swcTop.sv
testbench/tbSwcTop.sv

// ==== common/swcPkg.sv ====
`default_nettype none

`include "swc_params.svh"

package swcPkg;

   // counter instruction word
   typedef struct packed {
      logic [`SWC_CODE_WIDTH-1:0]                 code;
      logic [`SWC_INST_WIDTH-`SWC_CODE_WIDTH-1:0] imm;
   } swcInstT;

   // device view, carries a counter instruction
   typedef struct packed {
      logic [`CMD_TARGET_WIDTH-1:0] target;
      swcInstT                      inst;
   } cmdDevT;

   // wait view, blocks the stream until ready matches
   typedef struct packed {
      logic [`CMD_TARGET_WIDTH-1:0]   target;
      logic                           untilReady;
      logic [`CMD_WIDTH-`CMD_TARGET_WIDTH-2:0] spare;
   } cmdWaitT;

   // target sits in the top nibble of both views
   typedef union packed {
      cmdDevT  dev;
      cmdWaitT waitCmd;
   } cmdWordT;

endpackage

`default_nettype wire

// ==== common/swc_params.svh ====
`ifndef SWC_PARAMS_SVH
`define SWC_PARAMS_SVH

`define SWC_WIDTH        24 // counter register
`define SWC_INST_WIDTH   12 // code plus immediate
`define SWC_CODE_WIDTH   4
`define CMD_WIDTH        16 // host command word
`define CMD_TARGET_WIDTH 4

`define CMD_TARGET_DEV   4'h0
`define CMD_TARGET_WAIT  4'h1

// counter codes; 9 to 15 trap to error
`define SWC_NOP          4'h0
`define SWC_LD0          4'h1 // load byte 0
`define SWC_LD1          4'h2
`define SWC_LD2          4'h3
`define SWC_COU          4'h4 // single step up
`define SWC_COD          4'h5
`define SWC_CCU          4'h6 // run up until zero
`define SWC_CCD          4'h7
`define SWC_CCS          4'h8 // stop running count

`endif

// ==== hdl/cmdDispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "swc_params.svh"

module cmdDispatch (
   input  wire logic           clock,
   input  wire logic           reset,
   input  wire logic           i_cmdValid,
   input  wire swcPkg::cmdWordT i_cmd,
   input  wire logic           i_ready,
   output logic                o_cmdTake,
   output swcPkg::swcInstT     o_inst,
   output logic                o_instEn,
   output logic                o_busy,
   output logic                o_badCmd
);
   import swcPkg::*;

   cmdWaitT held;
   logic    holding;
   logic    match;
   logic    xfer;
   logic    isDev;
   logic    isWait;
   logic    badCmd;

   assign isDev  = i_cmd.dev.target == `CMD_TARGET_DEV;
   assign isWait = i_cmd.waitCmd.target == `CMD_TARGET_WAIT;

   // held wait is satisfied this cycle
   assign match = holding && (i_ready == held.untilReady);

   assign o_cmdTake = !holding || match;
   assign xfer      = i_cmdValid && o_cmdTake;

   // device commands go straight through in the transfer cycle
   assign o_inst   = i_cmd.dev.inst;
   assign o_instEn = xfer && isDev;

   always_ff @(posedge clock) begin
      if (reset) begin
         holding <= 1'b0;
         badCmd  <= 1'b0;
      end
      else begin
         if (xfer && isWait) begin
            holding <= 1'b1;
         end
         else if (match) begin
            holding <= 1'b0;
         end

         if (xfer && !isDev && !isWait) begin
            badCmd <= 1'b1; // sticky, word is dropped
         end
      end
   end

   always_ff @(posedge clock) begin
      if (xfer && isWait) begin
         held <= i_cmd.waitCmd;
      end
   end

   assign o_busy   = holding;
   assign o_badCmd = badCmd;

endmodule

`default_nettype wire

// ==== hdl/cmdReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmdReceiver (
   input  wire logic           clock,
   input  wire logic           reset,
   input  wire logic           i_cmdReq,
   input  wire swcPkg::cmdWordT i_cmdWord,
   input  wire logic           i_cmdTake,
   output logic                o_cmdAck,
   output logic                o_cmdValid,
   output swcPkg::cmdWordT     o_cmd
);
   import swcPkg::*;

   logic    full;
   logic    ack;
   logic    capture;
   cmdWordT buffer;

   // new word only when the previous one has been handed on
   assign capture = i_cmdReq && !ack && !full;

   always_ff @(posedge clock) begin
      if (reset) begin
         full <= 1'b0;
         ack  <= 1'b0;
      end
      else begin
         if (capture) begin
            full <= 1'b1;
         end
         else if (i_cmdTake) begin
            full <= 1'b0; // dispatch took it
         end

         if (capture) begin
            ack <= 1'b1;
         end
         else if (!i_cmdReq) begin
            ack <= 1'b0; // host released req
         end
      end
   end

   always_ff @(posedge clock) begin
      if (capture) begin
         buffer <= i_cmdWord;
      end
   end

   assign o_cmdAck   = ack;
   assign o_cmdValid = full;
   assign o_cmd      = buffer;

endmodule

`default_nettype wire

// ==== hdl/swcTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "swc_params.svh"

module swcTop (
   input  wire logic                 clock,
   input  wire logic                 reset,
   input  wire logic                 i_cmdReq,
   input  wire swcPkg::cmdWordT      i_cmdWord,
   output logic                      o_cmdAck,
   output logic [`SWC_WIDTH-1:0]     o_counter,
   output logic                      o_ready,
   output logic                      o_error,
   output logic                      o_badCmd,
   output logic                      o_idle
);
   import swcPkg::*;

   logic    cmdValid;
   logic    cmdTake;
   cmdWordT cmd;
   swcInstT inst;
   logic    instEn;
   logic    busy;

   cmdReceiver cmdReceiver_inst (
      .clock      (clock),
      .reset      (reset),
      .i_cmdReq   (i_cmdReq),
      .i_cmdWord  (i_cmdWord),
      .i_cmdTake  (cmdTake),
      .o_cmdAck   (o_cmdAck),
      .o_cmdValid (cmdValid),
      .o_cmd      (cmd)
   );

   cmdDispatch cmdDispatch_inst (
      .clock      (clock),
      .reset      (reset),
      .i_cmdValid (cmdValid),
      .i_cmd      (cmd),
      .i_ready    (o_ready),
      .o_cmdTake  (cmdTake),
      .o_inst     (inst),
      .o_instEn   (instEn),
      .o_busy     (busy),
      .o_badCmd   (o_badCmd)
   );

   swcCounter swcCounter_inst (
      .clock      (clock),
      .reset      (reset),
      .i_inst     (inst),
      .i_instEn   (instEn),
      .o_counter  (o_counter),
      .o_ready    (o_ready),
      .o_error    (o_error)
   );

   // nothing buffered and no wait pending
   assign o_idle = !cmdValid && !busy;

endmodule

`default_nettype wire

// ==== swc/swcCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "swc_params.svh"

module swcCounter (
   input  wire logic                 clock,
   input  wire logic                 reset,
   input  wire swcPkg::swcInstT      i_inst,
   input  wire logic                 i_instEn,
   output logic [`SWC_WIDTH-1:0]     o_counter,
   output logic                      o_ready,
   output logic                      o_error
);

   localparam logic [1:0] stReset = 2'h0;
   localparam logic [1:0] stReady = 2'h1;
   localparam logic [1:0] stError = 2'h2;

   logic [1:0]                 state;
   logic [`SWC_CODE_WIDTH-1:0] cont;
   logic [`SWC_WIDTH-1:0]      count;
   logic                       isZero;

   assign isZero = count == '0;

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= stReset;
         cont  <= `SWC_NOP;
         count <= '0;
      end
      else begin
         case (state)
            stReset: begin
               state <= stReady; // one idle cycle before accepting
               cont  <= `SWC_NOP;
               count <= '0;
            end

            stReady: begin
               if (i_instEn) begin
                  case (i_inst.code)
                     `SWC_NOP: begin
                        cont <= `SWC_NOP;
                     end
                     `SWC_LD0: begin
                        cont  <= `SWC_NOP;
                        count <= {count[`SWC_WIDTH-1:8], i_inst.imm};
                     end
                     `SWC_LD1: begin
                        cont  <= `SWC_NOP;
                        count <= {count[`SWC_WIDTH-1:16], i_inst.imm, count[7:0]};
                     end
                     `SWC_LD2: begin
                        cont  <= `SWC_NOP;
                        count <= {i_inst.imm, count[15:0]};
                     end
                     `SWC_COU: begin
                        cont  <= `SWC_NOP;
                        count <= count + 1'b1;
                     end
                     `SWC_COD: begin
                        cont  <= `SWC_NOP;
                        count <= count - 1'b1;
                     end
                     `SWC_CCU: begin
                        cont  <= `SWC_CCU; // first step now
                        count <= count + 1'b1;
                     end
                     `SWC_CCD: begin
                        cont  <= `SWC_CCD;
                        count <= count - 1'b1;
                     end
                     `SWC_CCS: begin
                        cont <= `SWC_NOP;
                     end
                     default: begin
                        state <= stError; // illegal code
                        cont  <= `SWC_NOP;
                        count <= '0;
                     end
                  endcase
               end
               else begin
                  case (cont)
                     `SWC_CCU: begin
                        if (isZero) begin
                           cont <= `SWC_NOP;
                        end
                        else begin
                           count <= count + 1'b1;
                        end
                     end
                     `SWC_CCD: begin
                        if (isZero) begin
                           cont <= `SWC_NOP;
                        end
                        else begin
                           count <= count - 1'b1;
                        end
                     end
                     default: begin
                        cont <= `SWC_NOP;
                     end
                  endcase
               end
            end

            stError: begin
               cont  <= `SWC_NOP; // stuck until reset
               count <= '0;
            end

            default: begin
               state <= stError;
               cont  <= `SWC_NOP;
               count <= '0;
            end
         endcase
      end
   end

   assign o_counter = count;
   assign o_ready   = isZero;
   assign o_error   = state == stError;

endmodule

`default_nettype wire

// ==== testbench/tbSwcTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "swc_params.svh"

module tbSwcTop;
   import swcPkg::*;

   localparam int clockPeriod     = 40;
   localparam int handshakeCycles = 8;

   localparam logic [2:0] modeNormal  = 3'd0; // send, wait idle, check
   localparam logic [2:0] modePosted  = 3'd1; // send only
   localparam logic [2:0] modeStalled = 3'd2; // ack must wait for the pending stall
   localparam logic [2:0] modeFrozen  = 3'd3; // counter must hold still
   localparam logic [2:0] modeReset   = 3'd4;

   typedef struct packed {
      cmdWordT               word;
      logic [`SWC_WIDTH-1:0] expCount;
      logic                  expErr;
      logic                  expBad;
      logic                  chkCount;
      logic [2:0]            mode;
   } entryT;

   logic                  clock;
   logic                  reset;
   logic                  cmdReq;
   cmdWordT               cmdWord;
   logic                  cmdAck;
   logic [`SWC_WIDTH-1:0] counter;
   logic                  ready;
   logic                  error;
   logic                  badCmd;
   logic                  idle;

   entryT                 stimTable[$];
   int                    tableLen   = 0;
   int                    errorCount = 0;
   int unsigned           lcgState   = 12206;

   // reference model state
   logic [`SWC_WIDTH-1:0] mCount;
   logic [2:0]            mKnown; // which bytes are known
   logic [1:0]            mCont;  // 0 idle, 1 up, 2 down
   logic                  mErr;
   logic                  mBad;

   swcTop swcTop_inst (
      .clock     (clock),
      .reset     (reset),
      .i_cmdReq  (cmdReq),
      .i_cmdWord (cmdWord),
      .o_cmdAck  (cmdAck),
      .o_counter (counter),
      .o_ready   (ready),
      .o_error   (error),
      .o_badCmd  (badCmd),
      .o_idle    (idle)
   );

   initial begin
      clock = 1'b0;
      forever #(clockPeriod / 2) clock = ~clock;
   end

   function automatic logic [7:0] lcgNext();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[23:16];
   endfunction

   function automatic cmdWordT devWord(input logic [3:0] code, input logic [7:0] imm);
      cmdWordT w;
      w.dev.target    = `CMD_TARGET_DEV;
      w.dev.inst.code = code;
      w.dev.inst.imm  = imm;
      return w;
   endfunction

   function automatic cmdWordT waitWord(input logic untilReady);
      cmdWordT w;
      w.waitCmd.target     = `CMD_TARGET_WAIT;
      w.waitCmd.untilReady = untilReady;
      w.waitCmd.spare      = '0;
      return w;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         errorCount++;
      end
   endtask

   task automatic modelReset();
      mCount = '0;
      mKnown = 3'b111;
      mCont  = 2'd0;
      mErr   = 1'b0;
      mBad   = 1'b0;
   endtask

   task automatic modelApply(input cmdWordT w);
      logic [3:0] code;
      logic [7:0] imm;
      code = w.dev.inst.code;
      imm  = w.dev.inst.imm;
      if (w.dev.target == `CMD_TARGET_WAIT) begin
         if (w.waitCmd.untilReady && mCont != 2'd0) begin
            mCount = '0; // running count ends at zero
            mKnown = 3'b111;
            mCont  = 2'd0;
         end
      end
      else if (w.dev.target != `CMD_TARGET_DEV) begin
         mBad = 1'b1;
      end
      else if (!mErr) begin
         if (mCont != 2'd0) begin
            mKnown = 3'b000; // stopped somewhere mid-count
            mCont  = 2'd0;
         end
         case (code)
            `SWC_NOP, `SWC_CCS: ;
            `SWC_LD0: begin mCount[7:0]   = imm; mKnown[0] = 1'b1; end
            `SWC_LD1: begin mCount[15:8]  = imm; mKnown[1] = 1'b1; end
            `SWC_LD2: begin mCount[23:16] = imm; mKnown[2] = 1'b1; end
            `SWC_COU: begin mCount = mCount + 1'b1; if (mKnown != 3'b111) mKnown = '0; end
            `SWC_COD: begin mCount = mCount - 1'b1; if (mKnown != 3'b111) mKnown = '0; end
            `SWC_CCU: begin mCont = 2'd1; mKnown = '0; end
            `SWC_CCD: begin mCont = 2'd2; mKnown = '0; end
            default: begin
               mErr   = 1'b1;
               mCount = '0;
               mKnown = 3'b111;
            end
         endcase
      end
   endtask

   task automatic addEntry(input cmdWordT w, input logic [2:0] mode);
      entryT e;
      if (mode == modeReset) modelReset();
      else modelApply(w);
      e.word     = w;
      e.expCount = mCount;
      e.expErr   = mErr;
      e.expBad   = mBad;
      e.chkCount = mKnown == 3'b111;
      e.mode     = mode;
      stimTable.push_back(e);
   endtask

   task automatic buildTable();
      logic [7:0] r;
      modelReset();
      for (int round = 0; round < 2; round++) begin
         addEntry(devWord(`SWC_LD0, lcgNext()), modeNormal);
         addEntry(devWord(`SWC_LD1, lcgNext()), modeNormal);
         addEntry(devWord(`SWC_LD2, lcgNext()), modeNormal);
         for (int s = 0; s < 10; s++) begin
            r = lcgNext();
            addEntry(devWord(r[3] ? `SWC_COU : `SWC_COD, 8'h00), modeNormal);
         end
      end
      addEntry(devWord(`SWC_LD0, 8'h00), modeNormal); // wrap through zero
      addEntry(devWord(`SWC_LD1, 8'h00), modeNormal);
      addEntry(devWord(`SWC_LD2, 8'h00), modeNormal);
      addEntry(devWord(`SWC_COD, 8'h00), modeNormal);
      addEntry(devWord(`SWC_COU, 8'h00), modeNormal);
      addEntry(devWord(`SWC_COU, 8'h00), modeNormal);
      addEntry(16'h30A5, modeNormal); // target 3
      addEntry(devWord(`SWC_LD2, 8'hFF), modeNormal);
      addEntry(devWord(`SWC_LD1, 8'hFF), modeNormal);
      addEntry(devWord(`SWC_LD0, 8'hF0), modeNormal);
      addEntry(devWord(`SWC_CCU, 8'h00), modeNormal);
      addEntry(waitWord(1'b1), modeNormal);
      addEntry(devWord(`SWC_LD0, 8'h20), modeNormal);
      addEntry(devWord(`SWC_CCD, 8'h00), modeNormal);
      addEntry(waitWord(1'b1), modePosted);
      addEntry(devWord(`SWC_LD0, lcgNext() | 8'h01), modePosted);
      addEntry(devWord(`SWC_NOP, 8'h00), modeStalled);
      addEntry(devWord(`SWC_LD2, 8'h80), modeNormal);
      addEntry(devWord(`SWC_LD0, 8'h00), modeNormal);
      addEntry(devWord(`SWC_CCU, 8'h00), modeNormal);
      addEntry(devWord(`SWC_CCS, 8'h00), modeFrozen);
      addEntry(devWord(4'hA, 8'h00), modeNormal); // illegal code
      addEntry(devWord(`SWC_LD0, 8'h55), modeNormal);
      addEntry('0, modeReset);
      addEntry(devWord(`SWC_LD0, 8'h3C), modeNormal);
      addEntry(devWord(`SWC_LD1, 8'hA7), modeNormal);
      tableLen = stimTable.size();
   endtask

   task automatic applyReset();
      @(posedge clock);
      reset  <= 1'b1;
      cmdReq <= 1'b0;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      repeat (2) @(posedge clock); // counter leaves its reset state
      @(negedge clock);
   endtask

   task automatic sendWord(input cmdWordT w, input logic stalled,
                           input logic [`SWC_WIDTH-1:0] expCount);
      @(posedge clock);
      cmdReq  <= 1'b1;
      cmdWord <= w;
      @(negedge clock);
      while (!cmdAck) @(negedge clock);
      if (stalled) checkValue("o_counter at ack", counter, expCount);
      @(posedge clock);
      cmdReq <= 1'b0;
      @(negedge clock);
      while (cmdAck) @(negedge clock);
   endtask

   initial begin
      entryT                 e;
      logic [`SWC_WIDTH-1:0] first;
      reset   = 1'b1;
      cmdReq  = 1'b0;
      cmdWord = '0;
      buildTable();
      applyReset();
      for (int i = 0; i < tableLen; i++) begin
         e = stimTable[i];
         if (e.mode == modeReset) applyReset();
         else sendWord(e.word, e.mode == modeStalled, e.expCount);
         if (e.mode != modePosted) begin
            while (!idle) @(negedge clock);
            if (e.mode == modeFrozen) begin
               first = counter;
               repeat (10) @(negedge clock);
               checkValue("o_counter held", counter, first);
               checkValue("o_counter nonzero", first != '0, 1'b1);
            end
            if (e.chkCount) begin
               checkValue("o_counter", counter, e.expCount);
               checkValue("o_ready", ready, e.expCount == '0);
            end
            checkValue("o_error", error, e.expErr);
            checkValue("o_badCmd", badCmd, e.expBad);
         end
      end
      $display("checked %0d entries, errors: %0d", tableLen, errorCount);
      if (errorCount == 0) begin
         $display("*** TEST PASSED ***");
      end
      else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (tableLen > 0);
      #(tableLen * (handshakeCycles + 300) * clockPeriod);
      $display("timeout: the command sequence did not finish in time");
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
